// File: intra_mode_picker.f
rtl/intra_pkg.sv
rtl/intra_predictor.sv
rtl/mode_cost.sv
rtl/mode_selector.sv
rtl/intra_mode_picker.sv
verification/intra_checker.sv
verification/tb_intra_mode_picker.sv

// File: rtl/intra_mode_picker.sv
// Top level of the 4x4 intra mode decision, predictor into cost pipeline into selector
`timescale 1ns/1ps

module intra_mode_picker import intra_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  intra_req_t req,
    output logic       busy,
    output logic       done,
    output pick_t      result
);

    cand_t cand;
    logic  cand_valid;
    logic  cand_last;
    cost_t cost;
    logic  cost_valid;
    logic  cost_last;

    intra_predictor u_predictor (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .req        (req),
        .busy       (busy),
        .cand       (cand),
        .cand_valid (cand_valid),
        .cand_last  (cand_last)
    );

    mode_cost u_cost (
        .clk        (clk),
        .rst_n      (rst_n),
        .cand       (cand),
        .cand_valid (cand_valid),
        .cand_last  (cand_last),
        .cost       (cost),
        .cost_valid (cost_valid),
        .cost_last  (cost_last)
    );

    mode_selector u_selector (
        .clk        (clk),
        .rst_n      (rst_n),
        .cost       (cost),
        .cost_valid (cost_valid),
        .cost_last  (cost_last),
        .done       (done),
        .result     (result)
    );

endmodule

// File: rtl/intra_pkg.sv
// Shared sizes, mode encoding, cost table and bus structs for the intra mode picker
package intra_pkg;

    // ------------------------------------------------------------
    // Block geometry
    // ------------------------------------------------------------
    localparam int BLK_DIM   = 4;
    localparam int BLK_PIX   = BLK_DIM * BLK_DIM;
    localparam int NUM_MODES = 4;

    // Score scaling, sse carries a weight of 256
    localparam int SSE_SHIFT = 8;
    localparam int SSE_W     = 21;
    localparam int SCORE_W   = 34;

    // Cycles between the last candidate and the end of the cost pipeline
    localparam int PIPE_LAT  = 2;

    // Fill values for missing edges
    localparam logic [7:0] V_FILL  = 8'd127;
    localparam logic [7:0] H_FILL  = 8'd129;
    localparam logic [7:0] DC_FILL = 8'd128;

    // ------------------------------------------------------------
    // Pixel containers, row-major
    // ------------------------------------------------------------
    typedef logic [7:0] pixel_t;
    typedef pixel_t [BLK_PIX-1:0] block_t;
    typedef pixel_t [BLK_DIM-1:0] edge_t;

    typedef enum logic [1:0] {
        V_PRED  = 2'd0,
        H_PRED  = 2'd1,
        TM_PRED = 2'd2,
        DC_PRED = 2'd3
    } pred_mode_e;

    // Per-mode header cost, scaled by lambda
    localparam logic [15:0] FIXED_COST [NUM_MODES] = '{16'd663, 16'd919, 16'd872, 16'd919};

    typedef struct packed {
        block_t      src;
        edge_t       top;
        edge_t       left;
        pixel_t      top_left;
        logic        top_avail;
        logic        left_avail;
        logic [15:0] lambda;
    } intra_req_t;

    typedef struct packed {
        pred_mode_e  mode;
        block_t      pred;
        block_t      src;
        logic [15:0] lambda;
    } cand_t;

    typedef struct packed {
        pred_mode_e         mode;
        block_t             pred;
        logic [SSE_W-1:0]   sse;
        logic [SCORE_W-1:0] score;
    } cost_t;

    typedef struct packed {
        pred_mode_e         mode;
        block_t             pred;
        logic [SSE_W-1:0]   sse;
        logic [SCORE_W-1:0] score;
    } pick_t;

endpackage

// File: rtl/intra_predictor.sv
// Request capture and candidate issue, one predicted block per cycle in V, H, TM, DC order
`timescale 1ns/1ps

module intra_predictor import intra_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  intra_req_t req,
    output logic       busy,
    output cand_t      cand,
    output logic       cand_valid,
    output logic       cand_last
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DRAIN
    } state_e;

    state_e     state;
    logic [1:0] mode_cnt;
    logic [1:0] drain_cnt;
    logic       drain_done;
    logic       accept;
    logic       issue_last;
    intra_req_t req_q;

    block_t     pred_v;
    block_t     pred_h;
    block_t     pred_tm;
    block_t     pred_dc;
    block_t     pred_sel;
    logic [9:0] sum_top;
    logic [9:0] sum_left;
    pixel_t     dc_val;

    assign drain_done = (state == DRAIN) && (drain_cnt == 2'(PIPE_LAT));
    assign busy       = (state != IDLE) && !drain_done;
    assign accept     = start && !busy;
    assign issue_last = (state == ISSUE) && (mode_cnt == 2'(NUM_MODES - 1));

    // ------------------------------------------------------------
    // Sequencing
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            mode_cnt   <= '0;
            drain_cnt  <= '0;
            cand_valid <= 1'b0;
            cand_last  <= 1'b0;
        end else begin
            cand_valid <= (state == ISSUE);
            cand_last  <= issue_last;
            case (state)
                IDLE: begin
                    mode_cnt <= '0;
                    if (accept)
                        state <= ISSUE;
                end
                ISSUE: begin
                    mode_cnt <= mode_cnt + 2'd1;
                    if (issue_last) begin
                        state     <= DRAIN;
                        drain_cnt <= '0;
                    end
                end
                DRAIN: begin
                    // Back-to-back start lands on the done edge
                    if (drain_done) begin
                        mode_cnt <= '0;
                        state    <= accept ? ISSUE : IDLE;
                    end else begin
                        drain_cnt <= drain_cnt + 2'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            req_q <= req;
        if (state == ISSUE)
            cand <= '{mode: pred_mode_e'(mode_cnt), pred: pred_sel,
                      src: req_q.src, lambda: req_q.lambda};
    end

    // ------------------------------------------------------------
    // Prediction builders
    // ------------------------------------------------------------
    always_comb begin
        sum_top  = '0;
        sum_left = '0;
        for (int i = 0; i < BLK_DIM; i++) begin
            sum_top  = sum_top + 10'(req_q.top[i]);
            sum_left = sum_left + 10'(req_q.left[i]);
        end
        if (req_q.top_avail && req_q.left_avail)
            dc_val = pixel_t'((11'(sum_top) + 11'(sum_left) + 11'd4) >> 3);
        else if (req_q.top_avail)
            dc_val = pixel_t'((sum_top + 10'd2) >> 2);
        else if (req_q.left_avail)
            dc_val = pixel_t'((sum_left + 10'd2) >> 2);
        else
            dc_val = DC_FILL;
    end

    always_comb begin
        logic signed [9:0] tm;
        for (int r = 0; r < BLK_DIM; r++) begin
            for (int c = 0; c < BLK_DIM; c++) begin
                pred_v[r*BLK_DIM+c] = req_q.top_avail ? req_q.top[c] : V_FILL;
                pred_h[r*BLK_DIM+c] = req_q.left_avail ? req_q.left[r] : H_FILL;
                pred_dc[r*BLK_DIM+c] = dc_val;
                tm = $signed({2'b00, req_q.left[r]}) + $signed({2'b00, req_q.top[c]})
                   - $signed({2'b00, req_q.top_left});
                if (tm < 0)
                    tm = '0;
                else if (tm > 10'sd255)
                    tm = 10'sd255;
                // TM falls back to whichever edge exists
                if (req_q.top_avail && req_q.left_avail)
                    pred_tm[r*BLK_DIM+c] = tm[7:0];
                else if (req_q.top_avail)
                    pred_tm[r*BLK_DIM+c] = req_q.top[c];
                else if (req_q.left_avail)
                    pred_tm[r*BLK_DIM+c] = req_q.left[r];
                else
                    pred_tm[r*BLK_DIM+c] = H_FILL;
            end
        end
    end

    always_comb begin
        case (pred_mode_e'(mode_cnt))
            V_PRED:  pred_sel = pred_v;
            H_PRED:  pred_sel = pred_h;
            TM_PRED: pred_sel = pred_tm;
            default: pred_sel = pred_dc;
        endcase
    end

    a_no_issue_from_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cand_valid |-> state != IDLE);

endmodule

// File: rtl/mode_cost.sv
// Two-stage rate-distortion cost pipeline, squared error then score
`timescale 1ns/1ps

module mode_cost import intra_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  cand_t cand,
    input  logic  cand_valid,
    input  logic  cand_last,
    output cost_t cost,
    output logic  cost_valid,
    output logic  cost_last
);

    logic [15:0]      sq_d [BLK_PIX];
    logic [15:0]      sq_q [BLK_PIX];
    logic [31:0]      rate_d;
    logic [31:0]      rate_q;
    pred_mode_e       mode_q;
    block_t           pred_q;
    logic             valid_q;
    logic             last_q;
    logic [SSE_W-1:0] sse_sum;

    // ------------------------------------------------------------
    // Stage 1, per-pixel squared differences and lambda product
    // ------------------------------------------------------------
    always_comb begin
        logic [7:0] d;
        for (int i = 0; i < BLK_PIX; i++) begin
            d = (cand.src[i] > cand.pred[i]) ? cand.src[i] - cand.pred[i]
                                             : cand.pred[i] - cand.src[i];
            sq_d[i] = 16'(d) * 16'(d);
        end
        rate_d = 32'(FIXED_COST[cand.mode]) * 32'(cand.lambda);
    end

    always_ff @(posedge clk) begin
        sq_q   <= sq_d;
        rate_q <= rate_d;
        mode_q <= cand.mode;
        pred_q <= cand.pred;
    end

    // ------------------------------------------------------------
    // Stage 2, error sum and score
    // ------------------------------------------------------------
    always_comb begin
        sse_sum = '0;
        for (int i = 0; i < BLK_PIX; i++)
            sse_sum = sse_sum + SSE_W'(sq_q[i]);
    end

    always_ff @(posedge clk) begin
        cost.mode  <= mode_q;
        cost.pred  <= pred_q;
        cost.sse   <= sse_sum;
        cost.score <= SCORE_W'(rate_q) + (SCORE_W'(sse_sum) << SSE_SHIFT);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q    <= 1'b0;
            last_q     <= 1'b0;
            cost_valid <= 1'b0;
            cost_last  <= 1'b0;
        end else begin
            valid_q    <= cand_valid;
            last_q     <= cand_valid && cand_last;
            cost_valid <= valid_q;
            cost_last  <= last_q;
        end
    end

    // Valid strobe and the data path stay on the same beat
    a_cost_latency: assert property (@(posedge clk) disable iff (!rst_n)
        cand_valid |-> ##PIPE_LAT (cost_valid && cost.mode == $past(cand.mode, PIPE_LAT)));

    a_no_stray_cost: assert property (@(posedge clk) disable iff (!rst_n)
        cost_valid |-> $past(cand_valid, PIPE_LAT));

endmodule

// File: rtl/mode_selector.sv
// Running minimum over scored candidates, reports the winner with a done pulse
`timescale 1ns/1ps

module mode_selector import intra_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  cost_t cost,
    input  logic  cost_valid,
    input  logic  cost_last,
    output logic  done,
    output pick_t result
);

    logic  first;
    logic  take_new;
    cost_t best;
    cost_t best_next;

    // Strict less keeps the earlier mode on a tie
    assign take_new  = first || (cost.score < best.score);
    assign best_next = take_new ? cost : best;

    always_ff @(posedge clk) begin
        if (cost_valid)
            best <= best_next;
    end

    // ------------------------------------------------------------
    // Control and result
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            first  <= 1'b1;
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= cost_valid && cost_last;
            if (cost_valid)
                first <= cost_last;
            if (cost_valid && cost_last) begin
                result.mode  <= best_next.mode;
                result.pred  <= best_next.pred;
                result.sse   <= best_next.sse;
                result.score <= best_next.score;
            end
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the intra mode picker simulation with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_intra_mode_picker -f intra_mode_picker.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_intra_mode_picker > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "simulation ended without a verdict"; exit 1; }
echo "simulation passed"
exit 0

// File: verification/intra_checker.sv
// Reference model and scoreboard for the intra mode picker, instantiated by the testbench
`timescale 1ns/1ps

module intra_checker import intra_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  intra_req_t req,
    input  logic       busy,
    input  logic       done,
    input  pick_t      result,
    output int         checked,
    output int         errors,
    output int         pending
);

    pick_t want_q[$];
    int    due_q[$];
    int    cyc = 0;
    int    last_acc = 0;
    logic  have_acc = 1'b0;

    initial begin
        checked = 0;
        errors  = 0;
        pending = 0;
    end

    function automatic int header_cost(input int m);
        case (m)
            0: return 663;
            1: return 919;
            2: return 872;
            default: return 919;
        endcase
    endfunction

    // ------------------------------------------------------------
    // Reference prediction and selection
    // ------------------------------------------------------------
    function automatic block_t predict(input intra_req_t r, input int m);
        block_t b;
        int     v;
        int     dc;
        int     sum;
        int     n;
        sum = 0;
        n   = 0;
        for (int i = 0; i < 4; i++) begin
            if (r.top_avail)
                sum += int'(r.top[i]);
            if (r.left_avail)
                sum += int'(r.left[i]);
        end
        n  = (r.top_avail ? 4 : 0) + (r.left_avail ? 4 : 0);
        dc = (n == 0) ? 128 : (sum + n / 2) / n;
        for (int ri = 0; ri < 4; ri++) begin
            for (int ci = 0; ci < 4; ci++) begin
                case (m)
                    0: v = r.top_avail ? int'(r.top[ci]) : 127;
                    1: v = r.left_avail ? int'(r.left[ri]) : 129;
                    2: begin
                        if (r.top_avail && r.left_avail) begin
                            v = int'(r.left[ri]) + int'(r.top[ci]) - int'(r.top_left);
                            v = (v < 0) ? 0 : ((v > 255) ? 255 : v);
                        end else if (r.top_avail) begin
                            v = int'(r.top[ci]);
                        end else if (r.left_avail) begin
                            v = int'(r.left[ri]);
                        end else begin
                            v = 129;
                        end
                    end
                    default: v = dc;
                endcase
                b[ri*4+ci] = 8'(v);
            end
        end
        return b;
    endfunction

    function automatic pick_t reference_pick(input intra_req_t r);
        pick_t  best;
        block_t p;
        longint sse;
        longint score;
        longint best_score;
        int     d;
        best       = '0;
        best_score = 0;
        for (int m = 0; m < 4; m++) begin
            p   = predict(r, m);
            sse = 0;
            for (int i = 0; i < 16; i++) begin
                d = int'(r.src[i]) - int'(p[i]);
                sse += longint'(d * d);
            end
            score = longint'(header_cost(m)) * longint'(r.lambda) + sse * 256;
            // Earlier mode survives a tie
            if (m == 0 || score < best_score) begin
                best.mode  = pred_mode_e'(m);
                best.pred  = p;
                best.sse   = 21'(sse);
                best.score = 34'(score);
                best_score = score;
            end
        end
        return best;
    endfunction

    task automatic flag_value(input string what, input logic [127:0] got,
                              input logic [127:0] want);
        $display("[FAIL] %0t %s got %0h expected %0h", $time, what, got, want);
        errors++;
    endtask

    // ------------------------------------------------------------
    // Comparison at each done, start tracking
    // ------------------------------------------------------------
    always @(posedge clk) begin
        pick_t want;
        int    due;
        int    errs_before;
        logic  busy_want;
        if (!rst_n) begin
            cyc      = 0;
            have_acc = 1'b0;
        end else begin
            cyc++;
            // Busy covers the six edges after an accepted start
            busy_want = have_acc && (cyc - last_acc >= 1) && (cyc - last_acc <= 6);
            if (busy !== busy_want) begin
                $display("[FAIL] %0t busy is %b, expected %b", $time, busy, busy_want);
                errors++;
            end
            if (done) begin
                if (want_q.size() == 0) begin
                    $display("done pulsed at %0t with no accepted start waiting", $time);
                    errors++;
                end else begin
                    want        = want_q.pop_front();
                    due         = due_q.pop_front();
                    errs_before = errors;
                    if (cyc != due) begin
                        $display("[FAIL] %0t done came %0d cycles after start, expected 7",
                                 $time, cyc - due + 7);
                        errors++;
                    end
                    if (result.mode !== want.mode)
                        flag_value("mode", 128'(result.mode), 128'(want.mode));
                    if (result.score !== want.score)
                        flag_value("score", 128'(result.score), 128'(want.score));
                    if (result.sse !== want.sse)
                        flag_value("sse", 128'(result.sse), 128'(want.sse));
                    if (result.pred !== want.pred)
                        flag_value("pred", result.pred, want.pred);
                    checked++;
                    $display("request %0d mode %0d score %0d sse %0d %s", checked,
                             result.mode, result.score, result.sse,
                             (errors == errs_before) ? "match" : "mismatch");
                end
            end else if (due_q.size() > 0 && cyc > due_q[0]) begin
                $display("no done arrived for the start taken at cycle %0d", due_q[0] - 8);
                errors++;
                void'(want_q.pop_front());
                void'(due_q.pop_front());
            end
            // A new start is taken seven edges after the last accepted one
            if (start && (!have_acc || cyc - last_acc >= 7)) begin
                want_q.push_back(reference_pick(req));
                due_q.push_back(cyc + 8);
                have_acc = 1'b1;
                last_acc = cyc;
            end
        end
        pending = want_q.size();
    end

endmodule

// File: verification/tb_intra_mode_picker.sv
// Testbench top for the intra mode picker, drives requests and ends the run on a verdict
`timescale 1ns/1ps

module tb_intra_mode_picker import intra_pkg::*; ();

    localparam int N_RAND     = 8;
    localparam int N_ONE      = 4;
    localparam int N_NONE     = 2;
    localparam int N_B2B      = 4;
    localparam int N_BLOCKS   = N_RAND + 2 * N_ONE + N_NONE + 1 + N_B2B;
    localparam int MAX_CYCLES = 12 * N_BLOCKS + 50;

    logic        clk;
    logic        rst_n;
    logic        start;
    intra_req_t  req;
    logic        busy;
    logic        done;
    pick_t       result;
    int          checked;
    int          errors;
    int          pending;
    int          cycles = 0;
    logic [31:0] lfsr = 32'haa9c_f842;

    intra_mode_picker intra_mode_picker_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .req    (req),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    intra_checker intra_checker_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .req     (req),
        .busy    (busy),
        .done    (done),
        .result  (result),
        .checked (checked),
        .errors  (errors),
        .pending (pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, run passed %0d cycles with %0d requests open", MAX_CYCLES, pending);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic make_req(input logic ta, input logic la, output intra_req_t r);
        logic [31:0] v;
        r = '0;
        for (int i = 0; i < BLK_DIM; i++) begin
            rand_bits(8, v);
            r.top[i] = v[7:0];
            rand_bits(8, v);
            r.left[i] = v[7:0];
        end
        rand_bits(8, v);
        r.top_left = v[7:0];
        rand_bits(7, v);
        r.lambda = 16'(v[6:0]);
        // Rows lean on top or left so different modes win
        for (int i = 0; i < BLK_PIX; i++) begin
            rand_bits(4, v);
            r.src[i] = (((i / 4) % 2) == 0 ? r.top[i % 4] : r.left[i / 4]) ^ 8'(v[3:0]);
        end
        r.top_avail  = ta;
        r.left_avail = la;
    endtask

    task automatic wait_idle();
        do
            @(negedge clk);
        while (pending != 0);
    endtask

    task automatic send_block(input intra_req_t r);
        @(posedge clk);
        start <= 1'b1;
        req   <= r;
        @(posedge clk);
        start <= 1'b0;
        wait_idle();
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        intra_req_t r;
        rst_n = 1'b0;
        start = 1'b0;
        req   = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        for (int i = 0; i < N_RAND; i++) begin
            make_req(1'b1, 1'b1, r);
            send_block(r);
        end
        $display("finished test 1, random blocks with both edges");

        for (int i = 0; i < 2 * N_ONE; i++) begin
            make_req(i < N_ONE, i >= N_ONE, r);
            send_block(r);
        end
        $display("finished test 2, one edge available");

        for (int i = 0; i < N_NONE; i++) begin
            make_req(1'b0, 1'b0, r);
            send_block(r);
        end
        $display("finished test 3, no edges");

        make_req(1'b1, 1'b1, r);
        r.lambda = '0;
        for (int i = 0; i < BLK_PIX; i++)
            r.src[i] = r.top[i % 4];
        send_block(r);
        $display("finished test 4, zero lambda on a vertical source");

        // Accepted starts every 7 cycles, the one at t == 3 lands while busy
        for (int t = 0; t <= 7 * (N_B2B - 1); t++) begin
            make_req(1'b1, 1'b1, r);
            @(posedge clk);
            start <= ((t % 7) == 0) || (t == 3);
            req   <= r;
        end
        @(posedge clk);
        start <= 1'b0;
        wait_idle();
        $display("finished test 5, back-to-back starts");

        repeat (3) @(posedge clk);
        $display("checked %0d of %0d blocks, %0d errors", checked, N_BLOCKS, errors);
        if (checked != N_BLOCKS)
            $display("only %0d of %0d requests produced a result", checked, N_BLOCKS);
        if (errors == 0 && checked == N_BLOCKS)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
